/* design/cpu_pkg.sv */
package cpu_pkg;

	localparam int data_width = 32;

	// instruction field positions
	localparam int op_lsb = 25;
	localparam int rt_lsb = 20;
	localparam int ra_lsb = 15;
	localparam int rb_lsb = 10;
	localparam int sv_lsb = 8;
	localparam int br_sub_bit = 14;

	typedef enum logic [5:0] {
		ty_base = 6'b100000,
		addi    = 6'b101000,
		ori     = 6'b101100,
		xori    = 6'b101011,
		movi    = 6'b100010,
		lwi     = 6'b000010,
		swi     = 6'b001010,
		ty_ls   = 6'b011100,
		ty_b    = 6'b100110,
		jj      = 6'b100100
	} opcode_t;

	typedef enum logic [4:0] {
		add    = 5'b00000,
		sub    = 5'b00001,
		and_op = 5'b00010,
		xor_op = 5'b00011,
		or_op  = 5'b00100,
		slli   = 5'b01000,
		srli   = 5'b01001,
		rotri  = 5'b01011
	} base_sub_t;

	typedef enum logic [7:0] {
		lw = 8'b00000010,
		sw = 8'b00001010
	} ls_sub_t;

	// bit 14 of a ty_b word
	localparam logic beq = 1'b0;
	localparam logic bne = 1'b1;

	typedef enum logic [2:0] {
		src2_rb, src2_imm, src2_imm15_sl2, src2_rb_sv, src2_rt
	} alu_src2_t;

	typedef enum logic [1:0] {ext_zero5, ext_sign15, ext_zero15, ext_sign20} imm_ext_t;
	typedef enum logic [1:0] {wb_alu, wb_imm, wb_mem} wb_sel_t;
	typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jump} pc_sel_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_srl, alu_sll, alu_ror
	} alu_op_t;

endpackage

/* design/instruction_memory.sv */
module instruction_memory #(
	parameter int im_words = 256
) (
	input  logic                             clock,
	input  logic                             prog_write,
	input  logic [$clog2(im_words)-1:0]      prog_addr,
	input  logic [cpu_pkg::data_width-1:0]   prog_data,
	input  logic [cpu_pkg::data_width-1:0]   pc,
	output logic [cpu_pkg::data_width-1:0]   instruction
);
	import cpu_pkg::*;

	localparam int index_bits = $clog2(im_words);

	logic [data_width-1:0] mem [im_words];
	logic [index_bits-1:0] fetch_index;

	// program load, only used while the core sits in reset
	always_ff @(posedge clock) begin
		if (prog_write) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// byte pc to word index
	assign fetch_index = pc[index_bits+1:2];
	assign instruction = mem[fetch_index];

endmodule

/* design/pc_unit.sv */
module pc_unit #(
	parameter int im_words = 256
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             enable_writeback,
	input  cpu_pkg::pc_sel_t                 pc_select,
	input  logic [13:0]                      imm_14bit,
	input  logic [23:0]                      imm_24bit,
	output logic [cpu_pkg::data_width-1:0]   pc
);
	import cpu_pkg::*;

	// byte address bits covering the program store
	localparam int pc_bits = $clog2(im_words) + 2;

	logic [pc_bits-1:0]    pc_reg;
	logic [data_width-1:0] pc_next;

	assign pc = {{(data_width-pc_bits){1'b0}}, pc_reg};

	// offsets are halfword counts
	always_comb begin
		case (pc_select)
			pc_branch: pc_next = pc + {{17{imm_14bit[13]}}, imm_14bit, 1'b0};
			pc_jump:   pc_next = pc + {{7{imm_24bit[23]}}, imm_24bit, 1'b0};
			default:   pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc_reg <= '0;
		end else if (enable_writeback) begin
			pc_reg <= pc_next[pc_bits-1:0];
		end
	end

	a_pc_aligned: assert property (@(posedge clock) disable iff (reset) pc_reg[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

/* design/controller.sv */
module controller (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [cpu_pkg::data_width-1:0]   instruction,
	input  logic                             alu_zero,
	output logic                             enable_fetch,
	output logic                             enable_decode,
	output logic                             enable_execute,
	output logic                             enable_memaccess,
	output logic                             enable_writeback,
	output logic [4:0]                       reg_ra_addr,
	output logic [4:0]                       reg_rb_addr,
	output logic [4:0]                       reg_rt_addr,
	output logic [4:0]                       imm_5bit,
	output logic [13:0]                      imm_14bit,
	output logic [14:0]                      imm_15bit,
	output logic [19:0]                      imm_20bit,
	output logic [23:0]                      imm_24bit,
	output logic [1:0]                       sub_op_sv,
	output cpu_pkg::alu_op_t                 alu_op,
	output cpu_pkg::alu_src2_t               alu_src2_select,
	output cpu_pkg::imm_ext_t                imm_extend_select,
	output cpu_pkg::wb_sel_t                 write_reg_select,
	output cpu_pkg::pc_sel_t                 pc_select,
	output logic                             dm_read,
	output logic                             dm_write_request,
	output logic                             do_reg_write
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		st_fetch, st_decode, st_execute, st_memaccess, st_writeback
	} state_t;

	state_t                state;
	logic [data_width-1:0] instruction_reg;
	opcode_t               opcode;
	base_sub_t             sub_op_base;
	ls_sub_t               sub_op_ls;
	logic                  sub_op_b;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
		end else begin
			case (state)
				st_fetch:     state <= st_decode;
				st_decode:    state <= st_execute;
				st_execute:   state <= st_memaccess;
				st_memaccess: state <= st_writeback;
				default:      state <= st_fetch;
			endcase
		end
	end

	assign enable_fetch     = (state == st_fetch);
	assign enable_decode    = (state == st_decode);
	assign enable_execute   = (state == st_execute);
	assign enable_memaccess = (state == st_memaccess);
	assign enable_writeback = (state == st_writeback);

	// all decode below works off this copy
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instruction_reg <= '0;
		end else if (enable_fetch) begin
			instruction_reg <= instruction;
		end
	end

	assign opcode      = opcode_t'(instruction_reg[op_lsb +: 6]);
	assign sub_op_base = base_sub_t'(instruction_reg[4:0]);
	assign sub_op_ls   = ls_sub_t'(instruction_reg[7:0]);
	assign sub_op_b    = instruction_reg[br_sub_bit];
	assign sub_op_sv   = instruction_reg[sv_lsb +: 2];

	assign reg_rt_addr = instruction_reg[rt_lsb +: 5];
	assign reg_ra_addr = instruction_reg[ra_lsb +: 5];
	assign reg_rb_addr = instruction_reg[rb_lsb +: 5];
	assign imm_5bit    = instruction_reg[rb_lsb +: 5];
	assign imm_14bit   = instruction_reg[13:0];
	assign imm_15bit   = instruction_reg[14:0];
	assign imm_20bit   = instruction_reg[19:0];
	assign imm_24bit   = instruction_reg[23:0];

	always_comb begin
		alu_op            = alu_add;
		alu_src2_select   = src2_rb;
		imm_extend_select = ext_zero5;
		write_reg_select  = wb_alu;
		dm_read           = 1'b0;
		dm_write_request  = 1'b0;
		do_reg_write      = 1'b0;
		case (opcode)
			ty_base: begin
				do_reg_write = 1'b1;
				case (sub_op_base)
					add:    alu_op = alu_add;
					sub:    alu_op = alu_sub;
					and_op: alu_op = alu_and;
					or_op:  alu_op = alu_or;
					xor_op: alu_op = alu_xor;
					srli, slli, rotri: begin
						alu_src2_select = src2_imm;
						if (sub_op_base == srli) begin
							alu_op = alu_srl;
						end else if (sub_op_base == slli) begin
							alu_op = alu_sll;
						end else begin
							alu_op = alu_ror;
						end
					end
					default: do_reg_write = 1'b0;
				endcase
			end
			addi, ori, xori: begin
				alu_src2_select   = src2_imm;
				imm_extend_select = (opcode == addi) ? ext_sign15 : ext_zero15;
				alu_op            = (opcode == addi) ? alu_add :
					(opcode == ori) ? alu_or : alu_xor;
				do_reg_write      = 1'b1;
			end
			movi: begin
				imm_extend_select = ext_sign20;
				write_reg_select  = wb_imm;
				do_reg_write      = 1'b1;
			end
			lwi, swi: begin
				alu_src2_select  = src2_imm15_sl2;
				write_reg_select = wb_mem;
				dm_read          = (opcode == lwi);
				dm_write_request = (opcode == swi);
				do_reg_write     = (opcode == lwi);
			end
			ty_ls: begin
				alu_src2_select  = src2_rb_sv;
				write_reg_select = wb_mem;
				dm_read          = (sub_op_ls == lw);
				dm_write_request = (sub_op_ls == sw);
				do_reg_write     = (sub_op_ls == lw);
			end
			ty_b: begin
				// compare only, zero flag means equal
				alu_op          = alu_sub;
				alu_src2_select = src2_rt;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		pc_select = pc_plus4;
		if (opcode == ty_b) begin
			if ((sub_op_b == beq && alu_zero) || (sub_op_b == bne && !alu_zero)) begin
				pc_select = pc_branch;
			end
		end else if (opcode == jj) begin
			pc_select = pc_jump;
		end
	end

	a_one_enable: assert property (@(posedge clock) disable iff (reset)
		$onehot({enable_fetch, enable_decode, enable_execute, enable_memaccess,
			enable_writeback}))
		else $error("state enables not one-hot");

	a_rw_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(dm_read && dm_write_request))
		else $error("load and store requested together");

endmodule

/* design/register_file.sv */
module register_file (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [4:0]                       ra_addr,
	input  logic [4:0]                       rb_addr,
	input  logic [4:0]                       rt_addr,
	input  logic [4:0]                       debug_addr,
	input  logic                             write_enable,
	input  logic [4:0]                       write_addr,
	input  logic [cpu_pkg::data_width-1:0]   write_data,
	output logic [cpu_pkg::data_width-1:0]   ra_value,
	output logic [cpu_pkg::data_width-1:0]   rb_value,
	output logic [cpu_pkg::data_width-1:0]   rt_value,
	output logic [cpu_pkg::data_width-1:0]   debug_data
);
	import cpu_pkg::*;

	logic [data_width-1:0] regs [32];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	// read ports are combinational
	assign ra_value   = regs[ra_addr];
	assign rb_value   = regs[rb_addr];
	assign rt_value   = regs[rt_addr];
	assign debug_data = regs[debug_addr];

endmodule

/* design/operand_select.sv */
module operand_select (
	input  cpu_pkg::imm_ext_t                imm_extend_select,
	input  cpu_pkg::alu_src2_t               alu_src2_select,
	input  logic [4:0]                       imm_5bit,
	input  logic [14:0]                      imm_15bit,
	input  logic [19:0]                      imm_20bit,
	input  logic [1:0]                       sub_op_sv,
	input  logic [cpu_pkg::data_width-1:0]   rb_value,
	input  logic [cpu_pkg::data_width-1:0]   rt_value,
	output logic [cpu_pkg::data_width-1:0]   extended_imm,
	output logic [cpu_pkg::data_width-1:0]   alu_operand_b
);
	import cpu_pkg::*;

	always_comb begin
		case (imm_extend_select)
			ext_zero5:  extended_imm = {27'b0, imm_5bit};
			ext_sign15: extended_imm = {{17{imm_15bit[14]}}, imm_15bit};
			ext_zero15: extended_imm = {17'b0, imm_15bit};
			ext_sign20: extended_imm = {{12{imm_20bit[19]}}, imm_20bit};
			default:    extended_imm = '0;
		endcase
	end

	// word offset for lwi/swi, signed like the other offsets
	always_comb begin
		case (alu_src2_select)
			src2_imm:       alu_operand_b = extended_imm;
			src2_imm15_sl2: alu_operand_b = {{15{imm_15bit[14]}}, imm_15bit, 2'b00};
			src2_rb_sv:     alu_operand_b = rb_value << sub_op_sv;
			src2_rt:        alu_operand_b = rt_value;
			default:        alu_operand_b = rb_value;
		endcase
	end

endmodule

/* design/alu.sv */
module alu (
	input  cpu_pkg::alu_op_t                 alu_op,
	input  logic [cpu_pkg::data_width-1:0]   operand_a,
	input  logic [cpu_pkg::data_width-1:0]   operand_b,
	output logic [cpu_pkg::data_width-1:0]   result,
	output logic                             zero
);
	import cpu_pkg::*;

	logic [4:0]              shamt;
	logic [2*data_width-1:0] rotate_pair;

	// only the low five bits count for shifts
	assign shamt = operand_b[4:0];

	// rotate right via a doubled word
	assign rotate_pair = {operand_a, operand_a} >> shamt;

	always_comb begin
		case (alu_op)
			alu_add: begin
				result = operand_a + operand_b;
			end
			alu_sub: begin
				result = operand_a - operand_b;
			end
			alu_and: begin
				result = operand_a & operand_b;
			end
			alu_or: begin
				result = operand_a | operand_b;
			end
			alu_xor: begin
				result = operand_a ^ operand_b;
			end
			alu_srl: begin
				result = operand_a >> shamt;
			end
			alu_sll: begin
				result = operand_a << shamt;
			end
			alu_ror: begin
				result = rotate_pair[data_width-1:0];
			end
			default: begin
				result = operand_a + operand_b;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

/* design/data_memory.sv */
module data_memory #(
	parameter int dm_words = 256
) (
	input  logic                             clock,
	input  logic                             enable_memaccess,
	input  logic                             dm_read,
	input  logic                             dm_write_request,
	input  logic [cpu_pkg::data_width-1:0]   address,
	input  logic [cpu_pkg::data_width-1:0]   write_data,
	output logic [cpu_pkg::data_width-1:0]   read_data
);
	import cpu_pkg::*;

	localparam int index_bits = $clog2(dm_words);

	logic [data_width-1:0] mem [dm_words];
	logic [index_bits-1:0] word_index;

	assign word_index = address[index_bits+1:2];

	always_ff @(posedge clock) begin
		if (enable_memaccess && dm_write_request) begin
			mem[word_index] <= write_data;
		end
		if (enable_memaccess && dm_read) begin
			read_data <= mem[word_index];
		end
	end

	a_aligned: assert property (@(posedge clock)
		enable_memaccess && (dm_read || dm_write_request) |-> address[1:0] == 2'b00)
		else $error("misaligned data access at %h", address);

endmodule

/* design/cpu_top.sv */
module cpu_top #(
	parameter int im_words = 256,
	parameter int dm_words = 256
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             prog_write,
	input  logic [$clog2(im_words)-1:0]      prog_addr,
	input  logic [cpu_pkg::data_width-1:0]   prog_data,
	input  logic [4:0]                       debug_addr,
	output logic [cpu_pkg::data_width-1:0]   debug_data,
	output logic                             dm_write,
	output logic [cpu_pkg::data_width-1:0]   dm_addr,
	output logic [cpu_pkg::data_width-1:0]   dm_wdata
);
	import cpu_pkg::*;

	logic [data_width-1:0] pc, instruction;
	logic enable_fetch, enable_decode, enable_execute, enable_memaccess, enable_writeback;
	logic [4:0] reg_ra_addr, reg_rb_addr, reg_rt_addr, imm_5bit;
	logic [13:0] imm_14bit;
	logic [14:0] imm_15bit;
	logic [19:0] imm_20bit;
	logic [23:0] imm_24bit;
	logic [1:0] sub_op_sv;
	alu_op_t alu_op;
	alu_src2_t alu_src2_select;
	imm_ext_t imm_extend_select;
	wb_sel_t write_reg_select;
	pc_sel_t pc_select;
	logic dm_read, dm_write_request, do_reg_write;
	logic [data_width-1:0] ra_value, rb_value, rt_value, extended_imm, alu_operand_b;
	logic [data_width-1:0] operand_a_reg, operand_b_reg, alu_out, alu_result, read_data;
	logic [data_width-1:0] write_back_data;
	logic alu_zero_out, alu_zero;

	instruction_memory #(.im_words(im_words)) instruction_memory_inst (.*);
	pc_unit #(.im_words(im_words)) pc_unit_inst (.*);
	controller controller_inst (.*);

	register_file register_file_inst (
		.clock, .reset, .ra_addr(reg_ra_addr), .rb_addr(reg_rb_addr),
		.rt_addr(reg_rt_addr), .debug_addr, .write_enable(do_reg_write && enable_writeback),
		.write_addr(reg_rt_addr), .write_data(write_back_data),
		.ra_value, .rb_value, .rt_value, .debug_data
	);

	operand_select operand_select_inst (.*);

	alu alu_inst (
		.alu_op, .operand_a(operand_a_reg), .operand_b(operand_b_reg),
		.result(alu_out), .zero(alu_zero_out)
	);

	data_memory #(.dm_words(dm_words)) data_memory_inst (
		.clock, .enable_memaccess, .dm_read, .dm_write_request,
		.address(alu_result), .write_data(rt_value), .read_data
	);

	// operands at decode, result and flag at execute
	always_ff @(posedge clock) begin
		if (enable_decode) begin
			operand_a_reg <= ra_value;
			operand_b_reg <= alu_operand_b;
		end
		if (enable_execute) begin
			alu_result <= alu_out;
			alu_zero   <= alu_zero_out;
		end
	end

	always_comb begin
		case (write_reg_select)
			wb_imm:  write_back_data = extended_imm;
			wb_mem:  write_back_data = read_data;
			default: write_back_data = alu_result;
		endcase
	end

	assign dm_write = dm_write_request && enable_memaccess;
	assign dm_addr  = alu_result;
	assign dm_wdata = rt_value;

	a_prog_in_reset: assert property (@(posedge clock) prog_write |-> reset)
		else $error("program write while the core is running");

endmodule

/* testbench/cpu_tb.sv */
module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int im_words = 256;
	localparam int dm_words = 256;
	localparam int run_limit = 2000;
	localparam int store_timeout = 10;

	logic                          clock;
	logic                          reset;
	logic                          prog_write;
	logic [$clog2(im_words)-1:0]   prog_addr;
	logic [31:0]                   prog_data;
	logic [4:0]                    debug_addr;
	logic [31:0]                   debug_data;
	logic                          dm_write;
	logic [31:0]                   dm_addr;
	logic [31:0]                   dm_wdata;

	integer      seed;
	int          checks;
	int          errors;
	logic [31:0] program_q[$];
	logic [31:0] exp_addr_q[$];
	logic [31:0] exp_data_q[$];

	cpu_top #(.im_words(im_words), .dm_words(dm_words)) cpu_top_inst (
		.clock, .reset, .prog_write, .prog_addr, .prog_data,
		.debug_addr, .debug_data, .dm_write, .dm_addr, .dm_wdata
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// instruction encoders, opcode sits in bits 30:25
	function automatic logic [31:0] base_word(input base_sub_t sub_op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb);
		return {1'b0, ty_base, rt, ra, rb, 5'd0, sub_op};
	endfunction

	function automatic logic [31:0] imm_word(input opcode_t op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic logic [31:0] movi_word(input logic [4:0] rt, input logic [19:0] imm);
		return {1'b0, movi, rt, imm};
	endfunction

	function automatic logic [31:0] ls_word(input ls_sub_t sub_op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv);
		return {1'b0, ty_ls, rt, ra, rb, sv, sub_op};
	endfunction

	function automatic logic [31:0] branch_word(input logic kind, input logic [4:0] rt,
			input logic [4:0] ra, input logic [13:0] imm);
		return {1'b0, ty_b, rt, ra, kind, imm};
	endfunction

	function automatic logic [31:0] jump_word(input logic [23:0] imm);
		return {1'b0, jj, 1'b0, imm};
	endfunction

	// full 32-bit value in three steps
	task automatic load_value(input logic [4:0] rt, input logic [31:0] value);
		program_q.push_back(movi_word(rt, value[31:12]));
		program_q.push_back(base_word(slli, rt, rt, 5'd12));
		program_q.push_back(imm_word(ori, rt, rt, {3'b0, value[11:0]}));
	endtask

	// reset, load, release; the core parks on a jump to itself
	task automatic start_program();
		@(posedge clock);
		#1;
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		program_q.push_back(jump_word(24'd0));
		for (int i = 0; i < program_q.size(); i++) begin
			prog_write = 1'b1;
			prog_addr = i;
			prog_data = program_q[i];
			@(posedge clock);
			#1;
		end
		prog_write = 1'b0;
		@(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	task automatic run_cycles(input int count);
		int cycles;
		cycles = 0;
		while (cycles < count && cycles < run_limit) begin
			@(posedge clock);
			cycles++;
		end
		if (cycles < count) begin
			errors++;
			$display("Program run did not finish within %0d cycles", run_limit);
		end
		#1;
	endtask

	task automatic check_reg(input logic [4:0] addr, input logic [31:0] expected);
		@(posedge clock);
		#1;
		debug_addr = addr;
		@(negedge clock);
		check_value(debug_data, expected, $sformatf("register r%0d", addr));
	endtask

	task automatic check_stores_done();
		if (exp_addr_q.size() != 0) begin
			errors++;
			$display("%0d expected stores never happened", exp_addr_q.size());
			exp_addr_q.delete();
			exp_data_q.delete();
		end
	endtask

	// every store pulse must match the next expected one
	always @(negedge clock) begin
		if (dm_write === 1'b1) begin
			if (exp_addr_q.size() == 0) begin
				errors++;
				$display("Unexpected store at %0t ns to address %h", $time, dm_addr);
			end else begin
				check_value(dm_addr, exp_addr_q.pop_front(), "store address");
				check_value(dm_wdata, exp_data_q.pop_front(), "store data");
			end
		end
	end

	task automatic test_register_ops();
		logic [31:0] a;
		logic [31:0] b;
		a = $random(seed);
		b = $random(seed);
		program_q.delete();
		load_value(5'd1, a);
		load_value(5'd2, b);
		program_q.push_back(base_word(add, 5'd3, 5'd1, 5'd2));
		program_q.push_back(base_word(sub, 5'd4, 5'd1, 5'd2));
		program_q.push_back(base_word(and_op, 5'd5, 5'd1, 5'd2));
		program_q.push_back(base_word(or_op, 5'd6, 5'd1, 5'd2));
		program_q.push_back(base_word(xor_op, 5'd7, 5'd1, 5'd2));
		start_program();
		run_cycles(5 * program_q.size());
		check_reg(5'd1, a);
		check_reg(5'd2, b);
		check_reg(5'd3, a + b);
		check_reg(5'd4, a - b);
		check_reg(5'd5, a & b);
		check_reg(5'd6, a | b);
		check_reg(5'd7, a ^ b);
	endtask

	task automatic test_immediate_ops();
		logic [31:0] c;
		int sh_r;
		int sh_l;
		int rot;
		c = $random(seed);
		sh_r = $random(seed) & 31;
		sh_l = $random(seed) & 31;
		rot = $random(seed) & 31;
		program_q.delete();
		load_value(5'd1, c);
		program_q.push_back(imm_word(addi, 5'd2, 5'd1, 15'h7ff0));
		program_q.push_back(imm_word(ori, 5'd3, 5'd1, 15'h6a5a));
		program_q.push_back(imm_word(xori, 5'd4, 5'd1, 15'h4321));
		program_q.push_back(movi_word(5'd5, 20'h81234));
		program_q.push_back(base_word(srli, 5'd6, 5'd1, sh_r[4:0]));
		program_q.push_back(base_word(slli, 5'd7, 5'd1, sh_l[4:0]));
		program_q.push_back(base_word(rotri, 5'd8, 5'd1, rot[4:0]));
		start_program();
		run_cycles(5 * program_q.size());
		check_reg(5'd2, c - 32'd16);
		check_reg(5'd3, c | 32'h0000_6a5a);
		check_reg(5'd4, c ^ 32'h0000_4321);
		check_reg(5'd5, 32'hfff8_1234);
		check_reg(5'd6, c >> sh_r);
		check_reg(5'd7, c << sh_l);
		check_reg(5'd8, (c >> rot) | (c << (32 - rot)));
	endtask

	task automatic test_loads_stores();
		logic [31:0] d1;
		logic [31:0] d2;
		d1 = $random(seed);
		d2 = $random(seed);
		program_q.delete();
		program_q.push_back(movi_word(5'd1, 20'h00040));
		program_q.push_back(movi_word(5'd4, 20'd5));
		program_q.push_back(movi_word(5'd7, 20'h00060));
		load_value(5'd2, d1);
		load_value(5'd3, d2);
		// 0x40 + 3 words, then 0x40 + (5 << 2)
		program_q.push_back(imm_word(swi, 5'd2, 5'd1, 15'd3));
		program_q.push_back(ls_word(sw, 5'd3, 5'd1, 5'd4, 2'd2));
		program_q.push_back(imm_word(lwi, 5'd5, 5'd1, 15'd3));
		program_q.push_back(ls_word(lw, 5'd6, 5'd1, 5'd4, 2'd2));
		// negative word offset back to 0x4c
		program_q.push_back(imm_word(lwi, 5'd8, 5'd7, 15'h7ffb));
		exp_addr_q.push_back(32'h0000_004c);
		exp_data_q.push_back(d1);
		exp_addr_q.push_back(32'h0000_0054);
		exp_data_q.push_back(d2);
		start_program();
		run_cycles(5 * program_q.size());
		check_stores_done();
		check_reg(5'd5, d1);
		check_reg(5'd6, d2);
		check_reg(5'd8, d1);
	endtask

	task automatic test_branches();
		logic [31:0] v;
		v = $random(seed);
		program_q.delete();
		load_value(5'd1, v);
		program_q.push_back(base_word(add, 5'd2, 5'd1, 5'd0));
		program_q.push_back(imm_word(addi, 5'd3, 5'd1, 15'd1));
		// offsets count halfwords from the branch itself
		program_q.push_back(branch_word(beq, 5'd2, 5'd1, 14'd4));
		program_q.push_back(movi_word(5'd10, 20'd1));
		program_q.push_back(branch_word(beq, 5'd3, 5'd1, 14'd4));
		program_q.push_back(movi_word(5'd11, 20'd2));
		program_q.push_back(branch_word(bne, 5'd3, 5'd1, 14'd6));
		program_q.push_back(movi_word(5'd12, 20'd3));
		program_q.push_back(movi_word(5'd13, 20'd4));
		program_q.push_back(branch_word(bne, 5'd2, 5'd1, 14'd6));
		program_q.push_back(movi_word(5'd14, 20'd5));
		program_q.push_back(jump_word(24'd6));
		program_q.push_back(movi_word(5'd15, 20'd6));
		program_q.push_back(movi_word(5'd16, 20'd7));
		program_q.push_back(movi_word(5'd17, 20'd8));
		start_program();
		run_cycles(5 * program_q.size());
		check_reg(5'd10, 32'd0);
		check_reg(5'd11, 32'd2);
		check_reg(5'd12, 32'd0);
		check_reg(5'd13, 32'd0);
		check_reg(5'd14, 32'd5);
		check_reg(5'd15, 32'd0);
		check_reg(5'd16, 32'd0);
		check_reg(5'd17, 32'd8);
	endtask

	task automatic test_store_timing();
		int cycle;
		logic seen;
		program_q.delete();
		program_q.push_back(imm_word(swi, 5'd0, 5'd0, 15'd2));
		program_q.push_back(movi_word(5'd5, 20'h01234));
		program_q.push_back({1'b0, 6'b111111, 5'd5, 20'habcde});
		program_q.push_back({1'b0, ty_base, 5'd6, 5'd5, 5'd5, 5'd0, 5'b11111});
		program_q.push_back({1'b0, 6'b000000, 5'd7, 20'h12345});
		exp_addr_q.push_back(32'h0000_0008);
		exp_data_q.push_back(32'h0000_0000);
		start_program();
		cycle = 0;
		seen = 1'b0;
		while (!seen && cycle < store_timeout) begin
			@(negedge clock);
			cycle++;
			seen = dm_write;
		end
		if (!seen) begin
			errors++;
			$display("No store pulse seen within %0d cycles of reset release", store_timeout);
		end else begin
			check_value(cycle, 32'd4, "cycle of first store pulse");
			@(negedge clock);
			check_value(dm_write, 1'b0, "store strobe one cycle later");
		end
		run_cycles(5 * program_q.size());
		check_stores_done();
		for (int r = 0; r < 32; r++) begin
			check_reg(r, (r == 5) ? 32'h0000_1234 : 32'd0);
		end
	endtask

	initial begin
		reset = 1'b1;
		prog_write = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		debug_addr = '0;
		seed = 32'h7ad4f574;
		checks = 0;
		errors = 0;
		test_register_ops();
		test_immediate_ops();
		test_loads_stores();
		test_branches();
		test_store_timing();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* src.f */
design/cpu_pkg.sv
design/instruction_memory.sv
design/pc_unit.sv
design/controller.sv
design/register_file.sv
design/operand_select.sv
design/alu.sv
design/data_memory.sv
design/cpu_top.sv
testbench/cpu_tb.sv
